//--- src/rv_pkg.sv
// shared definitions for the RV32I SoC
// opcodes, memory access codes, core to RAM request struct, address map

package rv_pkg;

  localparam int xlen = 32;  // data width
  localparam int ram_words = 1024;  // RAM depth in words
  localparam logic [31:0] io_addr = 32'h0000_1000;  // output word, above RAM

  localparam int unsigned default_startup_wait = 16;  // silicon needs far more
  localparam int unsigned default_image_bytes = 256;

  // write sizes
  localparam logic [1:0] wr_none = 2'b00;
  localparam logic [1:0] wr_byte = 2'b01;
  localparam logic [1:0] wr_half = 2'b10;
  localparam logic [1:0] wr_word = 2'b11;

  // read sizes, bit 2 asks for sign extension
  localparam logic [2:0] rd_none   = 3'b000;
  localparam logic [2:0] rd_byte_u = 3'b001;
  localparam logic [2:0] rd_half_u = 3'b010;
  localparam logic [2:0] rd_byte_s = 3'b101;
  localparam logic [2:0] rd_half_s = 3'b110;
  localparam logic [2:0] rd_word   = 3'b111;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  typedef struct packed {
    logic            enable;      // request taken in every cycle it is high
    logic [1:0]      write_type;
    logic [2:0]      read_type;
    logic [xlen-1:0] address;     // byte address
    logic [xlen-1:0] data_in;     // store data, low bits used for byte and half
  } ramio_req_t;

endpackage

//--- src/registers.sv
// integer register file, 32 x 32 bit
// two combinational read ports, one clocked write port, x0 reads as zero

`timescale 1ns/1ps

module registers import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            rd_we,
  input  logic [xlen-1:0] rd_wdata,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rd_we && rd != 5'd0) begin  // writes to x0 are dropped
      regs[rd] <= rd_wdata;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  // an unknown enable or target would corrupt the file
  assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(rd_we) && (!rd_we || !$isunknown(rd)));

endmodule

//--- src/rv_core.sv
// reduced multi-cycle RV32I core
// boots by copying an image from SPI flash (read command 0x03) into RAM
// then runs it, fetch and execute per instruction plus store or load wait

`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter int unsigned StartupWaitCycles  = default_startup_wait,
  parameter int unsigned FlashTransferBytes = default_image_bytes
) (
  input  logic            clk,
  input  logic            rst_n,
  output logic            led,
  output ramio_req_t      mem_req,
  input  logic [xlen-1:0] mem_rdata,
  input  logic            mem_ready,
  input  logic            mem_busy,
  output logic            flash_clk,
  output logic            flash_mosi,
  output logic            flash_cs,
  input  logic            flash_miso,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd,
  output logic            rd_we,
  output logic [xlen-1:0] rd_wdata,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data
);

  typedef enum logic [3:0] {
    st_boot_init,
    st_boot_load_cmd,
    st_boot_send,
    st_boot_load_addr,
    st_boot_read,
    st_boot_start_write,
    st_boot_write,
    st_fetch,
    st_execute,
    st_store,
    st_load
  } state_e;

  state_e state;
  state_e return_state;  // where st_boot_send goes when done

  logic [31:0]     flash_counter;
  logic [23:0]     flash_shift;  // outgoing bits, msb first
  logic [4:0]      flash_bits;
  logic [7:0]      flash_byte;
  logic [1:0]      flash_byte_num;
  logic [31:0]     flash_word;
  logic [xlen-1:0] boot_addr;

  logic [xlen-1:0] pc;
  logic [xlen-1:0] ir;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [xlen-1:0] u_imm;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] s_imm;
  logic [xlen-1:0] b_imm;
  logic [xlen-1:0] j_imm;
  logic [xlen-1:0] alu_b;
  logic [4:0]      shamt;
  logic [xlen-1:0] alu_out;
  logic            branch_taken;
  logic [xlen-1:0] next_pc;
  logic [2:0]      load_type;
  logic [1:0]      store_type;

  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];
  assign rd     = ir[11:7];

  assign u_imm = {ir[31:12], 12'b0};
  assign i_imm = {{20{ir[31]}}, ir[31:20]};
  assign s_imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign b_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  assign j_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

  // one ALU for register and immediate forms
  assign alu_b = (opcode == op_reg) ? rs2_data : i_imm;
  assign shamt = alu_b[4:0];  // ir[24:20] for the immediate shifts

  always_comb begin
    case (funct3)
      3'b000: alu_out = (opcode == op_reg && ir[30]) ? rs1_data - alu_b : rs1_data + alu_b;
      3'b001: alu_out = rs1_data << shamt;
      3'b010: alu_out = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(alu_b)};
      3'b011: alu_out = {{(xlen-1){1'b0}}, rs1_data < alu_b};
      3'b100: alu_out = rs1_data ^ alu_b;
      3'b101: begin
        if (ir[30]) alu_out = $unsigned($signed(rs1_data) >>> shamt);
        else alu_out = rs1_data >> shamt;
      end
      3'b110: alu_out = rs1_data | alu_b;
      default: alu_out = rs1_data & alu_b;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000: branch_taken = (rs1_data == rs2_data);
      3'b001: branch_taken = (rs1_data != rs2_data);
      3'b100: branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      3'b101: branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110: branch_taken = (rs1_data < rs2_data);
      3'b111: branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
    next_pc = pc + 4;
    case (opcode)
      op_jal: next_pc = pc + j_imm;
      op_jalr: begin
        next_pc = rs1_data + i_imm;
        next_pc[0] = 1'b0;
      end
      op_branch: if (branch_taken) next_pc = pc + b_imm;
      default: ;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000: load_type = rd_byte_s;
      3'b001: load_type = rd_half_s;
      3'b010: load_type = rd_word;
      3'b100: load_type = rd_byte_u;
      3'b101: load_type = rd_half_u;
      default: load_type = rd_none;  // illegal
    endcase
    case (funct3)
      3'b000: store_type = wr_byte;
      3'b001: store_type = wr_half;
      3'b010: store_type = wr_word;
      default: store_type = wr_none;  // illegal
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_boot_init;
      return_state <= st_boot_init;
      flash_counter <= '0;
      flash_shift <= '0;
      flash_bits <= '0;
      flash_byte <= '0;
      flash_byte_num <= '0;
      flash_word <= '0;
      boot_addr <= '0;
      flash_clk <= 1'b0;
      flash_mosi <= 1'b0;
      flash_cs <= 1'b1;
      mem_req <= '0;
      pc <= '0;
      ir <= '0;
      rd_we <= 1'b0;
      rd_wdata <= '0;
      led <= 1'b1;
    end else begin
      case (state)
        st_boot_init: begin
          flash_counter <= flash_counter + 32'd1;
          if (flash_counter >= StartupWaitCycles) begin
            flash_counter <= '0;
            state <= st_boot_load_cmd;
          end
        end
        st_boot_load_cmd: begin
          flash_cs <= 1'b0;
          flash_shift <= {8'h03, 16'h0000};  // read command
          flash_bits <= 5'd8;
          return_state <= st_boot_load_addr;
          state <= st_boot_send;
        end
        st_boot_load_addr: begin
          flash_shift <= 24'h000000;  // image starts at flash address 0
          flash_bits <= 5'd24;
          flash_byte_num <= '0;
          return_state <= st_boot_read;
          state <= st_boot_send;
        end
        st_boot_send: begin
          if (!flash_counter[0]) begin  // clk low, put out next bit
            flash_counter <= 32'd1;
            flash_clk <= 1'b0;
            flash_mosi <= flash_shift[23];
            flash_shift <= {flash_shift[22:0], 1'b0};
            flash_bits <= flash_bits - 5'd1;
          end else begin
            flash_counter <= '0;
            flash_clk <= 1'b1;
            if (flash_bits == 5'd0) state <= return_state;
          end
        end
        st_boot_read: begin
          flash_counter <= flash_counter + 32'd1;
          if (!flash_counter[0]) begin
            flash_clk <= 1'b0;
            if (flash_counter[3:0] == 4'd0 && flash_counter != '0) begin  // byte every 16
              flash_word <= {flash_byte, flash_word[31:8]};  // little endian
              flash_byte_num <= flash_byte_num + 2'd1;
              if (flash_byte_num == 2'd3) state <= st_boot_start_write;
            end
          end else begin
            flash_clk <= 1'b1;
            flash_byte <= {flash_byte[6:0], flash_miso};  // sample on rising phase
          end
        end
        st_boot_start_write: begin
          if (!mem_busy) begin
            mem_req.enable <= 1'b1;
            mem_req.write_type <= wr_word;
            mem_req.read_type <= rd_none;
            mem_req.address <= boot_addr;
            mem_req.data_in <= flash_word;
            boot_addr <= boot_addr + 4;
            state <= st_boot_write;
          end
        end
        st_boot_write: begin
          mem_req.enable <= 1'b0;  // single write cycle
          if (!mem_req.enable && !mem_busy) begin
            if (boot_addr < FlashTransferBytes) begin
              state <= st_boot_read;
            end else begin
              flash_cs <= 1'b1;  // image done
              pc <= '0;
              state <= st_fetch;
            end
          end
        end
        st_fetch: begin
          rd_we <= 1'b0;
          if (!mem_req.enable) begin
            if (!mem_busy) begin  // issue read at pc
              mem_req.enable <= 1'b1;
              mem_req.write_type <= wr_none;
              mem_req.read_type <= rd_word;
              mem_req.address <= pc;
            end
          end else if (mem_ready) begin
            ir <= mem_rdata;
            mem_req.enable <= 1'b0;
            state <= st_execute;
          end
        end
        st_execute: begin
          pc <= next_pc;
          mem_req.enable <= 1'b1;  // prefetch next instruction by default
          mem_req.write_type <= wr_none;
          mem_req.read_type <= rd_word;
          mem_req.address <= next_pc;
          state <= st_fetch;
          case (opcode)
            op_lui: begin
              rd_we <= 1'b1;
              rd_wdata <= u_imm;
            end
            op_auipc: begin
              rd_we <= 1'b1;
              rd_wdata <= pc + u_imm;
            end
            op_jal, op_jalr: begin
              rd_we <= 1'b1;
              rd_wdata <= pc + 4;  // link
            end
            op_imm, op_reg: begin
              rd_we <= 1'b1;
              rd_wdata <= alu_out;
            end
            op_branch: begin
              if (funct3 == 3'b010 || funct3 == 3'b011) led <= 1'b0;
            end
            op_store: begin
              mem_req.write_type <= store_type;
              mem_req.read_type <= rd_none;
              mem_req.address <= rs1_data + s_imm;
              mem_req.data_in <= rs2_data;
              if (store_type == wr_none) led <= 1'b0;
              state <= st_store;
            end
            op_load: begin
              if (load_type == rd_none) begin
                led <= 1'b0;  // skip it, plain fetch follows
              end else begin
                mem_req.read_type <= load_type;
                mem_req.address <= rs1_data + i_imm;
                state <= st_load;
              end
            end
            default: led <= 1'b0;  // unknown opcode
          endcase
        end
        st_store: begin
          mem_req.enable <= 1'b0;
          if (!mem_req.enable && !mem_busy) state <= st_fetch;
        end
        st_load: begin
          if (mem_ready) begin
            rd_we <= 1'b1;
            rd_wdata <= mem_rdata;
            mem_req.enable <= 1'b0;  // fetch issues the next read
            state <= st_fetch;
          end
        end
        default: state <= st_boot_init;
      endcase
    end
  end

  // flash stays deselected once the program runs
  assert property (@(posedge clk) disable iff (!rst_n)
    (state inside {st_fetch, st_execute, st_store, st_load}) |-> flash_cs);

endmodule

//--- src/ramio.sv
// word organized RAM with byte, half word and word access
// load data sign or zero extended, plus one output word at io_addr
// reads answer one cycle after the request, writes raise busy for one cycle

`timescale 1ns/1ps

module ramio import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  ramio_req_t      mem_req,
  output logic [xlen-1:0] mem_rdata,
  output logic            mem_ready,
  output logic            mem_busy,
  output logic [xlen-1:0] io_data,
  output logic            io_valid
);

  localparam int aw = $clog2(ram_words);

  logic [xlen-1:0] mem [ram_words];
  logic [aw-1:0]   word_idx;
  logic            is_io;
  logic            io_write;
  logic [3:0]      lane_en;
  logic [xlen-1:0] lane_data;
  logic [xlen-1:0] rd_word_q;
  logic [1:0]      rd_off_q;
  logic [2:0]      rd_type_q;
  logic [7:0]      rd_byte;
  logic [15:0]     rd_half;

  assign word_idx = mem_req.address[aw+1:2];
  assign is_io    = (mem_req.address[xlen-1:2] == io_addr[xlen-1:2]);
  assign io_write = mem_req.enable && is_io && (mem_req.write_type == wr_word);

  // lanes from the low address bits, data replicated across them
  always_comb begin
    lane_en = 4'b0000;
    lane_data = mem_req.data_in;
    case (mem_req.write_type)
      wr_byte: begin
        lane_en = 4'b0001 << mem_req.address[1:0];
        lane_data = {4{mem_req.data_in[7:0]}};
      end
      wr_half: begin
        lane_en = mem_req.address[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{mem_req.data_in[15:0]}};
      end
      wr_word: lane_en = 4'b1111;
      default: lane_en = 4'b0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_req.enable && !is_io) begin  // io word never hits RAM
      for (int i = 0; i < 4; i++) begin
        if (lane_en[i]) mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
      end
    end
    rd_word_q <= mem[word_idx];
    rd_off_q  <= mem_req.address[1:0];
    rd_type_q <= mem_req.read_type;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_ready <= 1'b0;
      mem_busy <= 1'b0;
      io_valid <= 1'b0;
      io_data <= '0;
    end else begin
      mem_ready <= mem_req.enable && (mem_req.read_type != rd_none);
      mem_busy <= mem_req.enable && (mem_req.write_type != wr_none);
      io_valid <= io_write;
      if (io_write) io_data <= mem_req.data_in;
    end
  end

  assign rd_byte = rd_word_q[8*rd_off_q +: 8];
  assign rd_half = rd_off_q[1] ? rd_word_q[31:16] : rd_word_q[15:0];

  always_comb begin
    case (rd_type_q[1:0])
      rd_byte_u[1:0]: mem_rdata = {{24{rd_type_q[2] & rd_byte[7]}}, rd_byte};
      rd_half_u[1:0]: mem_rdata = {{16{rd_type_q[2] & rd_half[15]}}, rd_half};
      default: mem_rdata = rd_word_q;
    endcase
  end

  // the core asks for one direction at a time
  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req.enable |-> !(mem_req.write_type != wr_none && mem_req.read_type != rd_none));

endmodule

//--- src/soc.sv
// SoC top level
// RV32I core, register file and RAM, with SPI flash pins, led and output word

`timescale 1ns/1ps

module soc import rv_pkg::*; #(
  parameter int unsigned StartupWaitCycles  = default_startup_wait,
  parameter int unsigned FlashTransferBytes = default_image_bytes
) (
  input  logic            clk,
  input  logic            rst_n,
  output logic            led,
  output logic            flash_clk,
  output logic            flash_mosi,
  output logic            flash_cs,
  input  logic            flash_miso,
  output logic [xlen-1:0] io_data,
  output logic            io_valid
);

  ramio_req_t      mem_req;
  logic [xlen-1:0] mem_rdata;
  logic            mem_ready;
  logic            mem_busy;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic            rd_we;
  logic [xlen-1:0] rd_wdata;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  rv_core #(
    .StartupWaitCycles (StartupWaitCycles),
    .FlashTransferBytes(FlashTransferBytes)
  ) core_i (
    .clk,
    .rst_n,
    .led,
    .mem_req,
    .mem_rdata,
    .mem_ready,
    .mem_busy,
    .flash_clk,
    .flash_mosi,
    .flash_cs,
    .flash_miso,
    .rs1,
    .rs2,
    .rd,
    .rd_we,
    .rd_wdata,
    .rs1_data,
    .rs2_data
  );

  registers regs_i (
    .clk,
    .rst_n,
    .rs1,
    .rs2,
    .rd,
    .rd_we,
    .rd_wdata,
    .rs1_data,
    .rs2_data
  );

  ramio ram_i (
    .clk,
    .rst_n,
    .mem_req,
    .mem_rdata,
    .mem_ready,
    .mem_busy,
    .io_data,
    .io_valid
  );

endmodule

//--- tb/spi_flash_model.sv
// behavioral SPI flash for the boot sequence
// takes a 32 bit command and address word, then shifts out the byte image msb first

`timescale 1ns/1ps

module spi_flash_model #(
  parameter int ImageBytes = 256
) (
  input  logic flash_clk,
  input  logic flash_mosi,
  input  logic flash_cs,
  output logic flash_miso
);

  logic [7:0]  image [ImageBytes];  // preloaded by the testbench
  logic [31:0] cmd_word;  // command byte and 24 bit address
  int          rx_bits;
  int          data_edges;  // rising edges in the data phase
  int          tx_idx;

  initial begin
    flash_miso = 1'b0;
    cmd_word = '0;
    rx_bits = 0;
    data_edges = 0;
    tx_idx = 0;
  end

  always @(negedge flash_cs) begin  // new transfer
    cmd_word = '0;
    rx_bits = 0;
    data_edges = 0;
    tx_idx = 0;
    flash_miso = 1'b0;
  end

  always @(posedge flash_clk) begin
    if (!flash_cs) begin
      if (rx_bits < 32) begin
        cmd_word = {cmd_word[30:0], flash_mosi};
        rx_bits++;
      end else begin
        data_edges++;
      end
    end
  end

  // next data bit goes out while the clock is low
  always @(negedge flash_clk) begin
    if (!flash_cs && rx_bits >= 32) begin
      if ((tx_idx >> 3) < ImageBytes) flash_miso = image[tx_idx >> 3][7 - (tx_idx & 7)];
      else flash_miso = 1'b0;
      tx_idx++;
    end
  end

endmodule

//--- tb/tb_soc.sv
// testbench for the RV32I SoC
// program builders, flash image loading, reboot and output word checks
// directed tests for boot, ALU, memory sizes, control flow and illegal opcode

`timescale 1ns/1ps

module tb_soc import rv_pkg::*; ();

  localparam int image_bytes = 256;
  localparam int image_words = image_bytes / 4;
  localparam int limit = 20000;  // cycles per wait
  localparam logic [31:0] nop = 32'h0000_0013;

  logic        clk;
  logic        rst_n;
  logic        led;
  logic        flash_clk;
  logic        flash_mosi;
  logic        flash_cs;
  logic        flash_miso;
  logic [31:0] io_data;
  logic        io_valid;

  logic [31:0] prog [image_words];
  int          prog_len;
  logic [31:0] expected_q [$];
  int          errors;
  bit          hung;
  integer      seed;

  soc #(
    .StartupWaitCycles (4),
    .FlashTransferBytes(image_bytes)
  ) soc_i (
    .clk,
    .rst_n,
    .led,
    .flash_clk,
    .flash_mosi,
    .flash_cs,
    .flash_miso,
    .io_data,
    .io_valid
  );

  spi_flash_model #(.ImageBytes(image_bytes)) flash_i (
    .flash_clk,
    .flash_mosi,
    .flash_cs,
    .flash_miso
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(int off, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], op_branch};
  endfunction

  function automatic logic [31:0] j_type(int off, logic [4:0] rd);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, op_jal};
  endfunction

  // logical shift with the vacated top bits filled from the sign bit
  function automatic logic [31:0] shift_right_arith(logic [31:0] v, logic [4:0] n);
    return (v >> n) | ({32{v[31]}} & ~(32'hffff_ffff >> n));
  endfunction

  task automatic clear_program();
    for (int i = 0; i < image_words; i++) prog[i] = nop;
    prog_len = 0;
    expected_q.delete();
  endtask

  task automatic add_insn(input logic [31:0] insn);
    prog[prog_len] = insn;
    prog_len++;
  endtask

  task automatic set_io_pointer();
    add_insn({io_addr[31:12], 5'd31, op_lui});  // low 12 bits of io_addr are zero
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] up;
    up = value + 32'h800;  // compensates the sign of the low part
    add_insn({up[31:12], rd, op_lui});
    add_insn(i_type(value[11:0], rd, 3'b000, rd, op_imm));
  endtask

  task automatic store_io(input logic [4:0] rs);
    add_insn(s_type(12'd0, rs, 5'd31, 3'b010));  // x31 holds io_addr
  endtask

  task automatic check_equal(input string msg, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic wait_flash_cs(input logic level, input string what);
    int n;
    n = 0;
    while (!hung && flash_cs !== level && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!hung && flash_cs !== level) begin
      hung = 1'b1;
      $display("timeout: flash_cs never went %0d while %s", level, what);
    end
  endtask

  task automatic read_io(output logic [31:0] data);
    int n;
    bit got;
    n = 0;
    got = 1'b0;
    data = '0;
    while (!hung && !got && n < limit) begin
      @(negedge clk);  // io_valid is stable here
      n++;
      if (io_valid) begin
        data = io_data;
        got = 1'b1;
      end
    end
    if (!hung && !got) begin
      hung = 1'b1;
      $display("timeout: program wrote no output word at %0t ns", $time);
    end
  endtask

  // copy the program into flash, reboot and wait for the image copy to end
  task automatic run_program(input string name);
    for (int i = 0; i < image_words; i++) begin
      for (int b = 0; b < 4; b++) flash_i.image[4*i+b] = prog[i][8*b +: 8];
    end
    @(posedge clk);
    #2 rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1;
    wait_flash_cs(1'b0, {name, " boot start"});
    wait_flash_cs(1'b1, {name, " boot end"});
  endtask

  task automatic collect_results(input string name);
    logic [31:0] data;
    for (int i = 0; i < expected_q.size(); i++) begin
      read_io(data);
      if (!hung) check_equal($sformatf("%s word %0d", name, i), data, expected_q[i]);
    end
  endtask

  task automatic boot_test();
    clear_program();
    set_io_pointer();
    add_insn(i_type(12'h03c, 5'd0, 3'b000, 5'd3, op_imm));
    store_io(5'd3);
    add_insn(j_type(0, 5'd0));  // halt
    expected_q.push_back(32'h3c);
    run_program("boot");
    check_equal("flash command and address", flash_i.cmd_word, 32'h0300_0000);
    check_equal("flash data clocks", flash_i.data_edges, 8 * image_bytes);
    collect_results("boot");
  endtask

  task automatic imm_op(input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] exp);
    add_insn(i_type(imm, 5'd1, f3, 5'd3, op_imm));
    store_io(5'd3);
    expected_q.push_back(exp);
  endtask

  task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] exp);
    add_insn(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    store_io(5'd3);
    expected_q.push_back(exp);
  endtask

  task automatic arith_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [31:0] simm;
    logic [4:0]  sh;
    logic [19:0] up;
    logic [31:0] pc_now;
    a = $random(seed);
    b = $random(seed);
    imm = $random(seed);
    sh = $random(seed);
    up = $random(seed);
    simm = {{20{imm[11]}}, imm};
    clear_program();
    set_io_pointer();
    load_const(5'd1, a);
    load_const(5'd2, b);
    imm_op(3'b000, imm, a + simm);
    imm_op(3'b010, imm, ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0);
    imm_op(3'b011, imm, (a < simm) ? 32'd1 : 32'd0);
    imm_op(3'b100, imm, a ^ simm);
    imm_op(3'b110, imm, a | simm);
    imm_op(3'b111, imm, a & simm);
    imm_op(3'b001, {7'b0, sh}, a << sh);
    imm_op(3'b101, {7'b0, sh}, a >> sh);
    imm_op(3'b101, {7'b0100000, sh}, shift_right_arith(a, sh));
    reg_op(7'b0000000, 3'b000, a + b);
    reg_op(7'b0100000, 3'b000, a - b);
    reg_op(7'b0000000, 3'b001, a << b[4:0]);
    reg_op(7'b0000000, 3'b010, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    reg_op(7'b0000000, 3'b011, (a < b) ? 32'd1 : 32'd0);
    reg_op(7'b0000000, 3'b100, a ^ b);
    reg_op(7'b0000000, 3'b101, a >> b[4:0]);
    reg_op(7'b0100000, 3'b101, shift_right_arith(a, b[4:0]));
    reg_op(7'b0000000, 3'b110, a | b);
    reg_op(7'b0000000, 3'b111, a & b);
    add_insn({up, 5'd3, op_lui});
    store_io(5'd3);
    expected_q.push_back({up, 12'b0});
    pc_now = prog_len * 4;
    add_insn({up, 5'd3, op_auipc});
    store_io(5'd3);
    expected_q.push_back(pc_now + {up, 12'b0});
    add_insn(j_type(0, 5'd0));
    run_program("arith");
    collect_results("arith");
    check_equal("led after arithmetic program", {31'b0, led}, 32'd1);
  endtask

  task automatic load_io(input logic [2:0] f3, input logic [11:0] off, input logic [31:0] exp);
    add_insn(i_type(off, 5'd5, f3, 5'd4, op_load));
    store_io(5'd4);
    expected_q.push_back(exp);
  endtask

  task automatic memory_test();
    logic [31:0] wv;
    logic [31:0] hv;
    logic [31:0] bv;
    logic [31:0] w;
    wv = 32'h1357_9b2d;
    hv = 32'h0000_c3a5;
    bv = 32'h0000_0081;
    w = wv;
    w[31:16] = hv[15:0];  // half word at offset 2
    w[15:8] = bv[7:0];  // byte at offset 1
    clear_program();
    set_io_pointer();
    add_insn(i_type(12'h400, 5'd0, 3'b000, 5'd5, op_imm));  // data base
    load_const(5'd1, wv);
    load_const(5'd2, hv);
    load_const(5'd3, bv);
    add_insn(s_type(12'd0, 5'd1, 5'd5, 3'b010));
    add_insn(s_type(12'd2, 5'd2, 5'd5, 3'b001));
    add_insn(s_type(12'd1, 5'd3, 5'd5, 3'b000));
    load_io(3'b000, 12'd1, {{24{w[15]}}, w[15:8]});
    load_io(3'b000, 12'd0, {{24{w[7]}}, w[7:0]});
    load_io(3'b001, 12'd2, {{16{w[31]}}, w[31:16]});
    load_io(3'b100, 12'd1, {24'b0, w[15:8]});
    load_io(3'b101, 12'd2, {16'b0, w[31:16]});
    load_io(3'b010, 12'd0, w);
    add_insn(j_type(0, 5'd0));
    run_program("memory");
    collect_results("memory");
  endtask

  task automatic control_test();
    int jal_idx;
    clear_program();
    set_io_pointer();
    for (int r = 1; r <= 12; r++) add_insn(i_type(12'd0, 5'd0, 3'b000, r[4:0], op_imm));
    add_insn(i_type(12'd5, 5'd0, 3'b000, 5'd2, op_imm));
    add_insn(i_type(12'd1, 5'd1, 3'b000, 5'd1, op_imm));  // blt loop
    add_insn(b_type(-4, 5'd2, 5'd1, 3'b100));
    store_io(5'd1);
    add_insn(i_type(12'd3, 5'd0, 3'b000, 5'd6, op_imm));
    add_insn(i_type(12'hfff, 5'd6, 3'b000, 5'd6, op_imm));  // bne loop
    add_insn(i_type(12'd1, 5'd7, 3'b000, 5'd7, op_imm));
    add_insn(b_type(-8, 5'd0, 5'd6, 3'b001));
    store_io(5'd7);
    add_insn(i_type(12'd4, 5'd0, 3'b000, 5'd8, op_imm));
    add_insn(i_type(12'd1, 5'd0, 3'b000, 5'd10, op_imm));
    add_insn(i_type(12'd1, 5'd9, 3'b000, 5'd9, op_imm));  // bgeu loop
    add_insn(i_type(12'hfff, 5'd8, 3'b000, 5'd8, op_imm));
    add_insn(b_type(-8, 5'd10, 5'd8, 3'b111));
    store_io(5'd9);
    jal_idx = prog_len;
    add_insn(nop);  // call target filled in below
    store_io(5'd11);
    store_io(5'd12);
    add_insn(j_type(0, 5'd0));
    prog[jal_idx] = j_type((prog_len - jal_idx) * 4, 5'd11);
    add_insn(i_type(12'h05a, 5'd0, 3'b000, 5'd12, op_imm));  // subroutine
    add_insn(i_type(12'd0, 5'd11, 3'b000, 5'd0, op_jalr));
    expected_q.push_back(32'd5);
    expected_q.push_back(32'd3);
    expected_q.push_back(32'd4);
    expected_q.push_back(jal_idx * 4 + 4);
    expected_q.push_back(32'h5a);
    run_program("control");
    collect_results("control");
  endtask

  task automatic illegal_test();
    check_equal("led before illegal opcode", {31'b0, led}, 32'd1);
    clear_program();
    set_io_pointer();
    add_insn(32'hffff_ffff);  // opcode 7f is not RV32I
    load_const(5'd3, 32'h00c0_ffee);
    store_io(5'd3);
    add_insn(j_type(0, 5'd0));
    expected_q.push_back(32'h00c0_ffee);
    run_program("illegal");
    collect_results("illegal");
    check_equal("led after illegal opcode", {31'b0, led}, 32'd0);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    errors = 0;
    hung = 1'b0;
    seed = 32'h3b96;
    boot_test();
    arith_test();
    memory_test();
    control_test();
    illegal_test();
    $display("errors: %0d, timed out: %0d", errors, hung);
    if (errors == 0 && !hung) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- files.f
src/rv_pkg.sv
src/registers.sv
src/rv_core.sv
src/ramio.sv
src/soc.sv
tb/spi_flash_model.sv
tb/tb_soc.sv
